// File: rtl/cpu_consts.svh
// sizing macros for the 16-bit core; include wherever a width or depth is needed
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

////////////////////////////////////////
// datapath
////////////////////////////////////////

// machine word and register width
`define CPU_DW 16

// general purpose registers, r7 is the link register
`define CPU_NREG 8
`define CPU_RA_W 3

////////////////////////////////////////
// memories
////////////////////////////////////////

// depth of each word memory, instruction and data alike
`define CPU_MEM_WORDS 256

// word address taken from byte address bits 8:1
`define CPU_MEM_AW 8

`endif

// File: rtl/cpu_pkg.sv
// shared types of the core: opcodes, control fields and the retire record
`include "cpu_consts.svh"

package cpu_pkg;

    ////////////////////////////////////////
    // instruction encodings
    ////////////////////////////////////////

    typedef enum logic [4:0] {
        OP_HALT  = 5'b00000,
        OP_NOP   = 5'b00001,
        OP_J     = 5'b00100,
        OP_JR    = 5'b00101,
        OP_JAL   = 5'b00110,
        OP_ADDI  = 5'b01000,
        OP_SUBI  = 5'b01001,
        OP_XORI  = 5'b01010,
        OP_ANDNI = 5'b01011,
        OP_BEQZ  = 5'b01100,
        OP_BNEZ  = 5'b01101,
        OP_BLTZ  = 5'b01110,
        OP_BGEZ  = 5'b01111,
        OP_ST    = 5'b10000,
        OP_LD    = 5'b10001,
        OP_SLBI  = 5'b10010,
        OP_LBI   = 5'b11000,
        OP_BTR   = 5'b11001,
        OP_RGRP  = 5'b11011,
        OP_SEQ   = 5'b11100,
        OP_SLT   = 5'b11101,
        OP_SLE   = 5'b11110,
        OP_SCO   = 5'b11111
    } opcode_e;

    // sub is b minus a, andn is a and not b
    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_XOR, ALU_ANDN, ALU_PASSB, ALU_SLBI, ALU_BTR, ALU_SET
    } alu_op_e;

    typedef enum logic [1:0] {SET_EQ, SET_LT, SET_LE, SET_CO} set_sel_e;

    typedef enum logic [1:0] {IMM_SEXT5, IMM_ZEXT5, IMM_SEXT8, IMM_ZEXT8} imm_sel_e;

    // rs field, rt field, r-format rd field, link register
    typedef enum logic [1:0] {DST_RS, DST_RT, DST_RD, DST_R7} dst_sel_e;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC2} wb_sel_e;

    typedef enum logic [2:0] {BR_NONE, BR_EQZ, BR_NEZ, BR_LTZ, BR_GEZ} br_cond_e;

    ////////////////////////////////////////
    // bundles
    ////////////////////////////////////////

    typedef struct packed {
        alu_op_e  alu_op;
        set_sel_e set_sel;
        imm_sel_e imm_sel;
        logic     alu_src_imm;
        dst_sel_e dst_sel;
        wb_sel_e  wb_sel;
        logic     reg_wr;
        logic     mem_rd;
        logic     mem_wr;
        br_cond_e br_cond;
        logic     jump;
        logic     jump_reg;
        logic     halt;
    } ctrl_t;

    // one record per committed instruction
    typedef struct packed {
        logic                  valid;
        logic [`CPU_DW-1:0]    pc;
        logic                  reg_wr;
        logic [`CPU_RA_W-1:0]  wr_reg;
        logic [`CPU_DW-1:0]    wr_data;
    } retire_t;

endpackage

// File: rtl/ctrl_decode.sv
// opcode decoder of the core; turns an instruction word into the control bundle
`timescale 1ns/100ps
`include "cpu_consts.svh"

module ctrl_decode (
    input  logic [`CPU_DW-1:0] i_instr,
    output cpu_pkg::ctrl_t     o_ctrl,
    output logic               o_illegal
);

    cpu_pkg::opcode_e op;

    assign op = cpu_pkg::opcode_e'(i_instr[15:11]);

    always_comb begin
        // all zero is a harmless bubble
        o_ctrl    = '0;
        o_illegal = 1'b0;
        case (op)
            cpu_pkg::OP_HALT: begin
                o_ctrl.halt = 1'b1;
            end
            cpu_pkg::OP_NOP: begin
                o_ctrl.reg_wr = 1'b0;
            end
            cpu_pkg::OP_J: begin
                o_ctrl.jump = 1'b1;
            end
            cpu_pkg::OP_JAL: begin
                o_ctrl.jump    = 1'b1;
                o_ctrl.reg_wr  = 1'b1;
                o_ctrl.dst_sel = cpu_pkg::DST_R7;
                o_ctrl.wb_sel  = cpu_pkg::WB_PC2;
            end
            // jr target comes out of the alu as rs + sext(imm8)
            cpu_pkg::OP_JR: begin
                o_ctrl.jump_reg    = 1'b1;
                o_ctrl.alu_op      = cpu_pkg::ALU_ADD;
                o_ctrl.imm_sel     = cpu_pkg::IMM_SEXT8;
                o_ctrl.alu_src_imm = 1'b1;
            end
            cpu_pkg::OP_ADDI, cpu_pkg::OP_SUBI, cpu_pkg::OP_XORI, cpu_pkg::OP_ANDNI: begin
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.reg_wr      = 1'b1;
                o_ctrl.dst_sel     = cpu_pkg::DST_RT;
                o_ctrl.imm_sel     = i_instr[12] ? cpu_pkg::IMM_ZEXT5 : cpu_pkg::IMM_SEXT5;
                case (op)
                    cpu_pkg::OP_ADDI: o_ctrl.alu_op = cpu_pkg::ALU_ADD;
                    cpu_pkg::OP_SUBI: o_ctrl.alu_op = cpu_pkg::ALU_SUB;
                    cpu_pkg::OP_XORI: o_ctrl.alu_op = cpu_pkg::ALU_XOR;
                    default:          o_ctrl.alu_op = cpu_pkg::ALU_ANDN;
                endcase
            end
            // branch test is on rs, offset is sext(imm8)
            cpu_pkg::OP_BEQZ: begin
                o_ctrl.br_cond = cpu_pkg::BR_EQZ;
                o_ctrl.imm_sel = cpu_pkg::IMM_SEXT8;
            end
            cpu_pkg::OP_BNEZ: begin
                o_ctrl.br_cond = cpu_pkg::BR_NEZ;
                o_ctrl.imm_sel = cpu_pkg::IMM_SEXT8;
            end
            cpu_pkg::OP_BLTZ: begin
                o_ctrl.br_cond = cpu_pkg::BR_LTZ;
                o_ctrl.imm_sel = cpu_pkg::IMM_SEXT8;
            end
            cpu_pkg::OP_BGEZ: begin
                o_ctrl.br_cond = cpu_pkg::BR_GEZ;
                o_ctrl.imm_sel = cpu_pkg::IMM_SEXT8;
            end
            cpu_pkg::OP_ST: begin
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.mem_wr      = 1'b1;
            end
            cpu_pkg::OP_LD: begin
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.mem_rd      = 1'b1;
                o_ctrl.reg_wr      = 1'b1;
                o_ctrl.dst_sel     = cpu_pkg::DST_RT;
                o_ctrl.wb_sel      = cpu_pkg::WB_MEM;
            end
            cpu_pkg::OP_SLBI, cpu_pkg::OP_LBI: begin
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.reg_wr      = 1'b1;
                o_ctrl.dst_sel     = cpu_pkg::DST_RS;
                o_ctrl.alu_op  = (op == cpu_pkg::OP_LBI) ? cpu_pkg::ALU_PASSB : cpu_pkg::ALU_SLBI;
                o_ctrl.imm_sel = (op == cpu_pkg::OP_LBI) ? cpu_pkg::IMM_SEXT8 : cpu_pkg::IMM_ZEXT8;
            end
            cpu_pkg::OP_BTR: begin
                o_ctrl.alu_op  = cpu_pkg::ALU_BTR;
                o_ctrl.reg_wr  = 1'b1;
                o_ctrl.dst_sel = cpu_pkg::DST_RD;
            end
            // function bits pick add, sub, xor, andn
            cpu_pkg::OP_RGRP: begin
                o_ctrl.alu_op  = cpu_pkg::alu_op_e'({1'b0, i_instr[1:0]});
                o_ctrl.reg_wr  = 1'b1;
                o_ctrl.dst_sel = cpu_pkg::DST_RD;
            end
            cpu_pkg::OP_SEQ, cpu_pkg::OP_SLT, cpu_pkg::OP_SLE, cpu_pkg::OP_SCO: begin
                o_ctrl.alu_op  = cpu_pkg::ALU_SET;
                o_ctrl.set_sel = cpu_pkg::set_sel_e'(i_instr[12:11]);
                o_ctrl.reg_wr  = 1'b1;
                o_ctrl.dst_sel = cpu_pkg::DST_RD;
            end
            default: begin
                o_illegal = 1'b1;
            end
        endcase
    end

endmodule

// File: rtl/alu.sv
// main datapath ALU; arithmetic, logic, byte ops and set-compare for the core
`timescale 1ns/100ps
`include "cpu_consts.svh"

module alu (
    input  logic [`CPU_DW-1:0] i_a,
    input  logic [`CPU_DW-1:0] i_b,
    input  cpu_pkg::alu_op_e   i_op,
    input  cpu_pkg::set_sel_e  i_set_sel,
    output logic [`CPU_DW-1:0] o_result,
    output logic               o_zero,
    output logic               o_neg
);

    logic [`CPU_DW:0]   sum;
    logic [`CPU_DW-1:0] diff;
    logic               ovf;
    logic               b_ge_a;
    logic               set_bit;
    logic [`CPU_DW-1:0] rev;

    ////////////////////////////////////////
    // shared adder and subtractor
    ////////////////////////////////////////

    // carry out of sum feeds sco
    assign sum  = {1'b0, i_a} + {1'b0, i_b};
    assign diff = i_b - i_a;

    // signed overflow of b - a
    assign ovf = (i_b[`CPU_DW-1] != i_a[`CPU_DW-1]) &&
                 (diff[`CPU_DW-1] != i_b[`CPU_DW-1]);

    // true sign of b - a, so b >= a signed
    assign b_ge_a = ~(diff[`CPU_DW-1] ^ ovf);

    always_comb begin
        case (i_set_sel)
            cpu_pkg::SET_EQ: set_bit = (diff == '0);
            cpu_pkg::SET_LT: set_bit = b_ge_a & (diff != '0);
            cpu_pkg::SET_LE: set_bit = b_ge_a;
            default:         set_bit = sum[`CPU_DW];
        endcase
    end

    // bit reverse of a for btr
    always_comb begin
        for (int i = 0; i < `CPU_DW; i++) begin
            rev[i] = i_a[`CPU_DW-1-i];
        end
    end

    ////////////////////////////////////////
    // result select
    ////////////////////////////////////////

    always_comb begin
        case (i_op)
            cpu_pkg::ALU_ADD:   o_result = sum[`CPU_DW-1:0];
            cpu_pkg::ALU_SUB:   o_result = diff;
            cpu_pkg::ALU_XOR:   o_result = i_a ^ i_b;
            cpu_pkg::ALU_ANDN:  o_result = i_a & ~i_b;
            cpu_pkg::ALU_PASSB: o_result = i_b;
            cpu_pkg::ALU_SLBI:  o_result = (i_a << 8) | i_b;
            cpu_pkg::ALU_BTR:   o_result = rev;
            default:            o_result = {{(`CPU_DW-1){1'b0}}, set_bit};
        endcase
    end

    // branch conditions look at rs itself
    assign o_zero = (i_a == '0);
    assign o_neg  = i_a[`CPU_DW-1];

endmodule

// File: rtl/reg_file.sv
// general purpose register file of the core; two read ports and one write port
`timescale 1ns/100ps
`include "cpu_consts.svh"

module reg_file (
    input  logic                 clk,
    input  logic                 i_arst_n,
    input  logic [`CPU_RA_W-1:0] i_rd1_sel,
    input  logic [`CPU_RA_W-1:0] i_rd2_sel,
    input  logic [`CPU_RA_W-1:0] i_wr_sel,
    input  logic [`CPU_DW-1:0]   i_wr_data,
    input  logic                 i_wr_en,
    output logic [`CPU_DW-1:0]   o_rd1_data,
    output logic [`CPU_DW-1:0]   o_rd2_data
);

    logic [`CPU_DW-1:0] regs [`CPU_NREG];

    // write lands at the commit edge
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < `CPU_NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en) begin
            regs[i_wr_sel] <= i_wr_data;
        end
    end

    // reads see the value before this cycle's write
    assign o_rd1_data = regs[i_rd1_sel];
    assign o_rd2_data = regs[i_rd2_sel];

endmodule

// File: rtl/word_mem.sv
// word memory with combinational read and clocked write; serves as imem and dmem
`timescale 1ns/100ps
`include "cpu_consts.svh"

module word_mem (
    input  logic                   clk,
    input  logic [`CPU_MEM_AW-1:0] i_addr,
    input  logic [`CPU_DW-1:0]     i_wr_data,
    input  logic                   i_wr_en,
    output logic [`CPU_DW-1:0]     o_rd_data
);

    logic [`CPU_DW-1:0] mem [`CPU_MEM_WORDS];

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_addr] <= i_wr_data;
        end
    end

    // read straight from the array, same cycle
    assign o_rd_data = mem[i_addr];

endmodule

// File: rtl/proc.sv
// single-cycle 16-bit processor top; load the program while stopped, then raise run
`timescale 1ns/100ps
`include "cpu_consts.svh"

module proc (
    input  logic                   clk,
    input  logic                   i_arst_n,
    input  logic                   i_run,
    input  logic                   i_load_en,
    input  logic [`CPU_MEM_AW-1:0] i_load_addr,
    input  logic [`CPU_DW-1:0]     i_load_data,
    output cpu_pkg::retire_t       o_retire,
    output logic                   o_halt,
    output logic                   o_err
);

    logic [`CPU_DW-1:0]     pc_q;
    logic                   halt_q;
    logic                   err_q;
    cpu_pkg::retire_t       retire_q;
    logic                   commit;
    logic [`CPU_MEM_AW-1:0] imem_addr;
    logic [`CPU_DW-1:0]     instr;
    cpu_pkg::ctrl_t         ctrl;
    logic                   illegal;
    logic [`CPU_DW-1:0]     rd1_data;
    logic [`CPU_DW-1:0]     rd2_data;
    logic [`CPU_RA_W-1:0]   wr_reg;
    logic [`CPU_DW-1:0]     wb_data;
    logic [`CPU_DW-1:0]     imm;
    logic [`CPU_DW-1:0]     alu_b;
    logic [`CPU_DW-1:0]     alu_result;
    logic                   alu_zero;
    logic                   alu_neg;
    logic [`CPU_DW-1:0]     dmem_rdata;
    logic [`CPU_DW-1:0]     load_data;
    logic [`CPU_DW-1:0]     pc_plus2;
    logic [`CPU_DW-1:0]     br_target;
    logic [`CPU_DW-1:0]     jmp_target;
    logic                   br_taken;
    logic [`CPU_DW-1:0]     pc_next;

    // one instruction per edge while running and not stopped
    assign commit = i_run & ~halt_q & ~err_q;

    ////////////////////////////////////////
    // fetch and decode
    ////////////////////////////////////////

    // load port owns imem while stopped
    assign imem_addr = i_run ? pc_q[`CPU_MEM_AW:1] : i_load_addr;

    word_mem u_imem (
        .clk       (clk),
        .i_addr    (imem_addr),
        .i_wr_data (i_load_data),
        .i_wr_en   (~i_run & i_load_en),
        .o_rd_data (instr)
    );

    ctrl_decode u_decode (
        .i_instr   (instr),
        .o_ctrl    (ctrl),
        .o_illegal (illegal)
    );

    always_comb begin
        case (ctrl.dst_sel)
            cpu_pkg::DST_RS: wr_reg = instr[10:8];
            cpu_pkg::DST_RT: wr_reg = instr[7:5];
            cpu_pkg::DST_RD: wr_reg = instr[4:2];
            default:         wr_reg = {`CPU_RA_W{1'b1}};
        endcase
    end

    reg_file u_regs (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_rd1_sel  (instr[10:8]),
        .i_rd2_sel  (instr[7:5]),
        .i_wr_sel   (wr_reg),
        .i_wr_data  (wb_data),
        .i_wr_en    (commit & ctrl.reg_wr),
        .o_rd1_data (rd1_data),
        .o_rd2_data (rd2_data)
    );

    ////////////////////////////////////////
    // execute and memory
    ////////////////////////////////////////

    always_comb begin
        case (ctrl.imm_sel)
            cpu_pkg::IMM_SEXT5: imm = {{(`CPU_DW-5){instr[4]}}, instr[4:0]};
            cpu_pkg::IMM_ZEXT5: imm = {{(`CPU_DW-5){1'b0}}, instr[4:0]};
            cpu_pkg::IMM_SEXT8: imm = {{(`CPU_DW-8){instr[7]}}, instr[7:0]};
            default:            imm = {{(`CPU_DW-8){1'b0}}, instr[7:0]};
        endcase
    end

    assign alu_b = ctrl.alu_src_imm ? imm : rd2_data;

    alu u_alu (
        .i_a       (rd1_data),
        .i_b       (alu_b),
        .i_op      (ctrl.alu_op),
        .i_set_sel (ctrl.set_sel),
        .o_result  (alu_result),
        .o_zero    (alu_zero),
        .o_neg     (alu_neg)
    );

    // byte address from the alu, word select from bits 8:1
    word_mem u_dmem (
        .clk       (clk),
        .i_addr    (alu_result[`CPU_MEM_AW:1]),
        .i_wr_data (rd2_data),
        .i_wr_en   (commit & ctrl.mem_wr),
        .o_rd_data (dmem_rdata)
    );

    assign load_data = ctrl.mem_rd ? dmem_rdata : '0;

    always_comb begin
        case (ctrl.wb_sel)
            cpu_pkg::WB_MEM: wb_data = load_data;
            cpu_pkg::WB_PC2: wb_data = pc_plus2;
            default:         wb_data = alu_result;
        endcase
    end

    ////////////////////////////////////////
    // next pc
    ////////////////////////////////////////

    assign pc_plus2   = pc_q + `CPU_DW'(2);
    assign br_target  = pc_plus2 + imm;
    assign jmp_target = pc_plus2 + {{(`CPU_DW-11){instr[10]}}, instr[10:0]};

    always_comb begin
        case (ctrl.br_cond)
            cpu_pkg::BR_EQZ: br_taken = alu_zero;
            cpu_pkg::BR_NEZ: br_taken = ~alu_zero;
            cpu_pkg::BR_LTZ: br_taken = alu_neg;
            cpu_pkg::BR_GEZ: br_taken = ~alu_neg;
            default:         br_taken = 1'b0;
        endcase
    end

    assign pc_next = ctrl.jump_reg ? alu_result :
                     ctrl.jump     ? jmp_target :
                     br_taken      ? br_target  : pc_plus2;

    // pc and the sticky stop flags
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q   <= '0;
            halt_q <= 1'b0;
            err_q  <= 1'b0;
        end else if (commit) begin
            pc_q <= pc_next;
            if (ctrl.halt) begin
                halt_q <= 1'b1;
            end
            if (illegal) begin
                err_q <= 1'b1;
            end
        end
    end

    // retire record, one cycle behind the commit edge
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            retire_q <= '0;
        end else begin
            retire_q.valid   <= commit;
            retire_q.pc      <= pc_q;
            retire_q.reg_wr  <= ctrl.reg_wr;
            retire_q.wr_reg  <= wr_reg;
            retire_q.wr_data <= wb_data;
        end
    end

    assign o_retire = retire_q;
    assign o_halt   = halt_q;
    assign o_err    = err_q;

endmodule

// File: testbench/proc_props.sv
// protocol properties of the proc top level; bound onto every proc instance
`timescale 1ns/100ps

module proc_props (
    input logic             clk,
    input logic             i_arst_n,
    input logic             i_run,
    input cpu_pkg::retire_t o_retire,
    input logic             o_halt,
    input logic             o_err
);

    // halt and error are sticky until reset
    a_halt_sticky: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_halt |=> o_halt)
        else $error("o_halt dropped without reset");

    a_err_sticky: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_err |=> o_err)
        else $error("o_err dropped without reset");

    // nothing retires once the core has stopped
    a_no_retire_stopped: assert property (@(posedge clk) disable iff (!i_arst_n)
        (o_halt || o_err) |=> !o_retire.valid)
        else $error("retire record after halt or error");

    // instruction addresses are word aligned
    a_pc_aligned: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_retire.valid |-> !o_retire.pc[0])
        else $error("retired pc is odd");

    a_no_retire_idle: assert property (@(posedge clk) disable iff (!i_arst_n)
        !i_run |=> !o_retire.valid)
        else $error("retire record while run was low");

endmodule

bind proc proc_props u_props (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_run    (i_run),
    .o_retire (o_retire),
    .o_halt   (o_halt),
    .o_err    (o_err)
);

// File: testbench/proc_tb.sv
// testbench for proc; loads programs from the golden file and checks every retire record
`timescale 1ns/100ps
`include "cpu_consts.svh"

module proc_tb;

    logic                   clk;
    logic                   i_arst_n;
    logic                   i_run;
    logic                   i_load_en;
    logic [`CPU_MEM_AW-1:0] i_load_addr;
    logic [`CPU_DW-1:0]     i_load_data;
    cpu_pkg::retire_t       o_retire;
    logic                   o_halt;
    logic                   o_err;

    logic [15:0] gold [0:255];
    int          gptr;
    int          errors;
    int          checks;

    always #2 clk = ~clk;

    proc u_proc (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_run       (i_run),
        .i_load_en   (i_load_en),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data),
        .o_retire    (o_retire),
        .o_halt      (o_halt),
        .o_err       (o_err)
    );

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR time=%0t %s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    function automatic logic [15:0] take_word();
        take_word = gold[gptr];
        gptr = gptr + 1;
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        i_arst_n  <= 1'b0;
        i_run     <= 1'b0;
        i_load_en <= 1'b0;
        repeat (4) @(posedge clk);
        i_arst_n <= 1'b1;
    endtask

    task automatic load_program(input int n_prog);
        for (int i = 0; i < n_prog; i++) begin
            @(posedge clk);
            i_load_en   <= 1'b1;
            i_load_addr <= i[`CPU_MEM_AW-1:0];
            i_load_data <= take_word();
        end
        @(posedge clk);
        i_load_en <= 1'b0;
    endtask

    task automatic run_program(input int n_prog, input int n_ret);
        int          limit;
        int          count;
        int          got;
        int          tail;
        logic [15:0] e_pc;
        logic [15:0] e_wr;
        logic [15:0] e_reg;
        logic [15:0] e_data;
        limit = 4 * n_ret + n_prog + 50;
        count = 0;
        got   = 0;
        tail  = 0;
        @(posedge clk);
        i_run <= 1'b1;
        while (tail <= 4 && count < limit) begin
            // outputs settle well before the falling edge
            @(negedge clk);
            count++;
            if (o_retire.valid) begin
                if (got < n_ret) begin
                    e_pc   = take_word();
                    e_wr   = take_word();
                    e_reg  = take_word();
                    e_data = take_word();
                    check_val("o_retire.pc", e_pc, o_retire.pc);
                    check_val("o_retire.reg_wr", e_wr, {15'b0, o_retire.reg_wr});
                    if (e_wr[0]) begin
                        check_val("o_retire.wr_reg", e_reg, {13'b0, o_retire.wr_reg});
                        check_val("o_retire.wr_data", e_data, o_retire.wr_data);
                    end
                    got++;
                end else begin
                    errors++;
                    $display("retire at pc %h after the last expected record", o_retire.pc);
                end
            end
            // watch a few more cycles once stopped
            if (o_halt || o_err) begin
                tail++;
            end
        end
        if (tail <= 4) begin
            $display("timeout: core did not stop within %0d cycles", limit);
            $display("Result: FAILED");
            $finish;
        end
        if (got != n_ret) begin
            errors++;
            $display("core stopped after %0d of %0d expected retires", got, n_ret);
            gptr = gptr + 4 * (n_ret - got);
        end
        check_val("o_halt", take_word(), {15'b0, o_halt});
        check_val("o_err", take_word(), {15'b0, o_err});
        @(posedge clk);
        i_run <= 1'b0;
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        logic [15:0] n_sec;
        logic [15:0] n_prog;
        logic [15:0] n_ret;
        clk         = 1'b0;
        i_arst_n    = 1'b0;
        i_run       = 1'b0;
        i_load_en   = 1'b0;
        i_load_addr = '0;
        i_load_data = '0;
        gptr        = 0;
        errors      = 0;
        checks      = 0;
        $readmemh("testbench/proc_golden.txt", gold);
        n_sec = take_word();
        if (^n_sec === 1'bx || n_sec == 0) begin
            errors++;
            $display("golden file is missing or holds no sections");
            n_sec = 0;
        end
        for (int s = 0; s < int'(n_sec); s++) begin
            apply_reset();
            n_prog = take_word();
            n_ret  = take_word();
            load_program(int'(n_prog));
            run_program(int'(n_prog), int'(n_ret));
        end
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: proc.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/ctrl_decode.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/word_mem.sv
rtl/proc.sv
testbench/proc_props.sv
testbench/proc_tb.sv

// File: Makefile
# Verilator build and run of the proc testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check sim.log for the pass line"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -f proc.f --top-module proc_tb -o proc_tb_sim
	./obj_dir/proc_tb_sim | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: testbench/proc_golden.txt
// section count, then per section: program length, retire count, program words,
// retire records (pc reg_wr wr_reg wr_data), final o_halt and o_err
0002
// arithmetic, set-compare, memory, branches, jumps, halt
0026 001E
C105 C2FD 9234 417D 4981 52BF 5AD4 C914
D978 D971 DA36 DA3B E12C EC34 F198 FA8C
815F 8BC3 6604 6E02 0000 7104 7902 0000
7402 0000 6702 0000 3004 0000 0000 2002
0000 2F0C 0000 7C06 0800 0000
0000 1 1 0005
0002 1 2 FFFD
0004 1 2 FD34
0006 1 3 0002
0008 1 4 FFFC
000A 1 5 FD2B
000C 1 6 FD20
000E 1 5 A000
0010 1 6 0007
0012 1 4 FFFD
0014 1 5 FD31
0016 1 6 FD30
0018 1 3 0001
001A 1 5 0001
001C 1 6 0000
001E 1 3 0001
0020 0 0 0000
0022 1 6 FD34
0024 0 0 0000
0026 0 0 0000
002A 0 0 0000
002C 0 0 0000
0030 0 0 0000
0034 0 0 0000
0038 1 7 003A
003E 0 0 0000
0042 0 0 0000
0046 0 0 0000
0048 0 0 0000
004A 0 0 0000
1 0
// undefined opcode stops the core
0004 0003
C17F 0800 1000 C201
0000 1 1 007F
0002 0 0 0000
0004 0 0 0000
0 1
